// File: design/fir_bus_pkg.sv
package fir_bus_pkg;

	// Register bus geometry
	localparam int BUS_AW    = 8;  // Word address width
	localparam int BUS_DW    = 32; // Data width
	localparam int BYTE_W    = 8;  // Width of one byte lane
	localparam int BUS_BYTES = BUS_DW / BYTE_W;

	// Host request, one word per transfer
	typedef struct packed {
		logic [BUS_AW-1:0]    addr;  // Word address
		logic                 we;    // 1 = write, 0 = read
		logic [BUS_DW-1:0]    wdata;
		logic [BUS_BYTES-1:0] wmask; // One bit per byte lane
	} bus_req_t;

	// Response to the host
	typedef struct packed {
		logic [BUS_DW-1:0] rdata;
		logic              err;   // Address out of range
	} bus_rsp_t;

endpackage

// File: design/fir_dsp_pkg.sv
package fir_dsp_pkg;

	// Filter geometry
	localparam int NUM_TAPS = 8;
	localparam int COEFF_AW = $clog2(NUM_TAPS);

	// Datapath widths
	localparam int COEFF_W   = 16;
	localparam int SAMPLE_W  = 16;
	localparam int ACC_W     = 40; // Headroom for the sum of all products
	localparam int FRAC_BITS = 14; // Coefficients are Q1.14

	typedef logic signed [COEFF_W-1:0]  coeff_t;
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [ACC_W-1:0]    acc_t;

	// Half an output LSB, added before the final shift
	localparam acc_t ROUND_HALF = acc_t'(1) <<< (FRAC_BITS - 1);

	// Clamp limits of the output sample
	localparam acc_t SAT_MAX = acc_t'(2 ** (SAMPLE_W - 1) - 1);
	localparam acc_t SAT_MIN = -acc_t'(2 ** (SAMPLE_W - 1));

endpackage

// File: design/coeff_bus_adapter.sv
module coeff_bus_adapter (
	input  logic                             clk_i,
	input  logic                             rst_ni,
	// Host request
	input  logic                             bus_req_valid_i,
	output logic                             bus_req_ready_o,
	input  fir_bus_pkg::bus_req_t            bus_req_i,
	// Host response
	output logic                             bus_rsp_valid_o,
	input  logic                             bus_rsp_ready_i,
	output fir_bus_pkg::bus_rsp_t            bus_rsp_o,
	// Coefficient memory, bus side
	output logic                             mem_req_o,
	output logic                             mem_we_o,
	output logic [fir_dsp_pkg::COEFF_AW-1:0] mem_addr_o,
	output fir_dsp_pkg::coeff_t              mem_wdata_o,
	output logic [1:0]                       mem_wmask_o,
	input  fir_dsp_pkg::coeff_t              mem_rdata_i
);
	import fir_bus_pkg::*;
	import fir_dsp_pkg::*;

	logic req_hs;
	logic rsp_hs;
	logic in_range;
	logic pending_q; // Response waiting for the host
	logic err_q;
	logic rd_q;      // Pending response carries memory read data

	assign req_hs   = bus_req_valid_i && bus_req_ready_o;
	assign rsp_hs   = bus_rsp_valid_o && bus_rsp_ready_i;
	assign in_range = (bus_req_i.addr < BUS_AW'(NUM_TAPS));

	// Only one request in flight
	assign bus_req_ready_o = !pending_q;
	assign bus_rsp_valid_o = pending_q;

	// Out-of-range requests never reach the memory
	assign mem_req_o   = req_hs && in_range;
	assign mem_we_o    = bus_req_i.we;
	assign mem_addr_o  = bus_req_i.addr[COEFF_AW-1:0];
	assign mem_wdata_o = bus_req_i.wdata[COEFF_W-1:0]; // Upper half is ignored
	assign mem_wmask_o = bus_req_i.wmask[1:0];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pending_q <= 1'b0;
			err_q     <= 1'b0;
			rd_q      <= 1'b0;
		end else if (req_hs) begin
			pending_q <= 1'b1;
			err_q     <= !in_range;
			rd_q      <= in_range && !bus_req_i.we;
		end else if (rsp_hs) begin
			pending_q <= 1'b0;
		end
	end

	// Memory holds its read register until the next strobe, so the data stays put
	always_comb begin
		bus_rsp_o.err   = err_q;
		bus_rsp_o.rdata = '0; // Writes and errors answer with zero
		if (rd_q) begin
			bus_rsp_o.rdata = {{(BUS_DW - COEFF_W){1'b0}}, mem_rdata_i};
		end
	end

	// A stalled response must not change before the host takes it
	rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_rsp_valid_o && !bus_rsp_ready_i |=> bus_rsp_valid_o && $stable(bus_rsp_o))
		else $error("bus response changed under back-pressure");

endmodule

// File: design/coeff_dpram.sv
module coeff_dpram (
	input  logic                             clk_i,
	input  logic                             rst_ni,
	// Bus port
	input  logic                             req_i,
	input  logic                             we_i,
	input  logic [fir_dsp_pkg::COEFF_AW-1:0] addr_i,
	input  fir_dsp_pkg::coeff_t              wdata_i,
	input  logic [1:0]                       wmask_i,
	output fir_dsp_pkg::coeff_t              rdata_o,
	// Coefficient read port
	input  logic                             coef_en_i,
	input  logic [fir_dsp_pkg::COEFF_AW-1:0] coef_addr_i,
	output fir_dsp_pkg::coeff_t              coef_o
);
	import fir_bus_pkg::*;
	import fir_dsp_pkg::*;

	coeff_t mem_q [NUM_TAPS];
	coeff_t wr_word; // Stored word after the masked write
	coeff_t rdata_q;
	coeff_t coef_q;
	logic   wr_en;

	assign wr_en = req_i && we_i;

	// Merge the enabled byte lanes into the current word
	always_comb begin
		wr_word = mem_q[addr_i];
		for (int b = 0; b < COEFF_W / BYTE_W; b++) begin
			if (wmask_i[b]) wr_word[b*BYTE_W +: BYTE_W] = wdata_i[b*BYTE_W +: BYTE_W];
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mem_q <= '{default: '0}; // Unloaded taps read as zero
		end else if (wr_en) begin
			mem_q[addr_i] <= wr_word;
		end
	end

	// Bus read, held until the next strobe
	always_ff @(posedge clk_i) begin
		if (req_i) rdata_q <= mem_q[addr_i];
	end

	// Coefficient read with forwarding of a same-cycle bus write
	always_ff @(posedge clk_i) begin
		if (coef_en_i) begin
			if (wr_en && (addr_i == coef_addr_i)) begin
				coef_q <= wr_word;
			end else begin
				coef_q <= mem_q[coef_addr_i];
			end
		end
	end

	assign rdata_o = rdata_q;
	assign coef_o  = coef_q;

	// An unknown address would touch an undefined tap
	addr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(req_i |-> !$isunknown(addr_i)) and (coef_en_i |-> !$isunknown(coef_addr_i)))
		else $error("coefficient memory address unknown");

endmodule

// File: design/fir_mac_engine.sv
module fir_mac_engine (
	input  logic                             clk_i,
	input  logic                             rst_ni,
	// Sample input
	input  logic                             in_valid_i,
	output logic                             in_ready_o,
	input  fir_dsp_pkg::sample_t             in_sample_i,
	// Filtered output
	output logic                             out_valid_o,
	input  logic                             out_ready_i,
	output fir_dsp_pkg::sample_t             out_sample_o,
	// Coefficient read port
	output logic                             coef_en_o,
	output logic [fir_dsp_pkg::COEFF_AW-1:0] coef_addr_o,
	input  fir_dsp_pkg::coeff_t              coef_i
);
	import fir_dsp_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE, // Waiting for a sample
		S_ADDR, // Issuing coefficient addresses
		S_LAST, // Last coefficient in flight
		S_OUT   // Result held for the consumer
	} state_e;

	state_e  state_q;
	logic    [COEFF_AW-1:0] addr_q;
	logic    [COEFF_AW-1:0] tap_q;  // Tap of the coefficient now on coef_i
	logic    data_vld_q;
	sample_t delay_q [NUM_TAPS];    // Index 0 holds the newest sample
	acc_t    acc_q;
	acc_t    acc_nxt;
	acc_t    rnd;
	acc_t    shifted;
	sample_t sat_res;
	sample_t out_sample_q;
	logic    in_hs;
	logic    signed [COEFF_W+SAMPLE_W-1:0] prod;

	assign in_ready_o   = (state_q == S_IDLE);
	assign in_hs        = in_valid_i && in_ready_o;
	assign out_valid_o  = (state_q == S_OUT);
	assign out_sample_o = out_sample_q;
	assign coef_en_o    = (state_q == S_ADDR);
	assign coef_addr_o  = addr_q;

	// One product per returned coefficient
	assign prod    = coef_i * delay_q[tap_q];
	assign acc_nxt = acc_q + acc_t'(prod);

	// Round half up, drop the fraction, clamp to the sample range
	always_comb begin
		rnd     = acc_nxt + ROUND_HALF;
		shifted = rnd >>> FRAC_BITS;
		if (shifted > SAT_MAX) begin
			sat_res = sample_t'(SAT_MAX);
		end else if (shifted < SAT_MIN) begin
			sat_res = sample_t'(SAT_MIN);
		end else begin
			sat_res = sample_t'(shifted);
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q    <= S_IDLE;
			addr_q     <= '0;
			data_vld_q <= 1'b0;
			delay_q    <= '{default: '0};
		end else begin
			data_vld_q <= coef_en_o;
			case (state_q)
				S_IDLE: begin
					if (in_hs) begin
						delay_q[0] <= in_sample_i;
						for (int i = 1; i < NUM_TAPS; i++) delay_q[i] <= delay_q[i-1];
						addr_q  <= '0;
						state_q <= S_ADDR;
					end
				end
				S_ADDR: begin
					addr_q <= addr_q + 1'b1;
					if (addr_q == COEFF_AW'(NUM_TAPS - 1)) state_q <= S_LAST;
				end
				S_LAST: state_q <= S_OUT;
				S_OUT: begin
					if (out_ready_i) state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Accumulator and result
	always_ff @(posedge clk_i) begin
		tap_q <= coef_addr_o;
		if (in_hs) begin
			acc_q <= '0;
		end else if (data_vld_q) begin
			acc_q <= acc_nxt;
		end
		if (state_q == S_LAST) out_sample_q <= sat_res; // Last product folded in here
	end

	out_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_sample_o))
		else $error("filter output changed under back-pressure");

endmodule

// File: design/fir_accel_top.sv
module fir_accel_top (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	// Coefficient register bus
	input  logic                  bus_req_valid_i,
	output logic                  bus_req_ready_o,
	input  fir_bus_pkg::bus_req_t bus_req_i,
	output logic                  bus_rsp_valid_o,
	input  logic                  bus_rsp_ready_i,
	output fir_bus_pkg::bus_rsp_t bus_rsp_o,
	// Sample stream
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  fir_dsp_pkg::sample_t  in_sample_i,
	output logic                  out_valid_o,
	input  logic                  out_ready_i,
	output fir_dsp_pkg::sample_t  out_sample_o
);
	import fir_dsp_pkg::*;

	// Bus side of the coefficient memory
	logic                mem_req;
	logic                mem_we;
	logic [COEFF_AW-1:0] mem_addr;
	coeff_t              mem_wdata;
	logic [1:0]          mem_wmask;
	coeff_t              mem_rdata;

	// Filter side of the coefficient memory
	logic                coef_en;
	logic [COEFF_AW-1:0] coef_addr;
	coeff_t              coef;

	coeff_bus_adapter coeff_bus_adapter_i (
		.clk_i, .rst_ni,
		.bus_req_valid_i, .bus_req_ready_o, .bus_req_i,
		.bus_rsp_valid_o, .bus_rsp_ready_i, .bus_rsp_o,
		.mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_wmask_o(mem_wmask), .mem_rdata_i(mem_rdata)
	);

	coeff_dpram coeff_dpram_i (
		.clk_i, .rst_ni,
		.req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr),
		.wdata_i(mem_wdata), .wmask_i(mem_wmask), .rdata_o(mem_rdata),
		.coef_en_i(coef_en), .coef_addr_i(coef_addr), .coef_o(coef)
	);

	fir_mac_engine fir_mac_engine_i (
		.clk_i, .rst_ni,
		.in_valid_i, .in_ready_o, .in_sample_i,
		.out_valid_o, .out_ready_i, .out_sample_o,
		.coef_en_o(coef_en), .coef_addr_o(coef_addr), .coef_i(coef)
	);

endmodule

// File: verification/fir_accel_tb.sv
module fir_accel_tb;
	import fir_bus_pkg::*;
	import fir_dsp_pkg::*;

	localparam int MAX_STALL    = 3;  // Longest back-pressure hold in cycles
	localparam int RAND_SAMPLES = 32;
	// Worst case per bus access: request, response, stall, accept
	localparam int BUS_OP_CYC   = 3 + MAX_STALL;
	localparam int SAMPLE_CYC   = NUM_TAPS + 4 + MAX_STALL;
	localparam int BUS_OPS      = 2 * NUM_TAPS + 5 + (4 + NUM_TAPS) + 2 * NUM_TAPS;
	localparam int SAMPLES      = NUM_TAPS + RAND_SAMPLES + 2 * NUM_TAPS;
	localparam int TIMEOUT_CYC  = BUS_OPS * BUS_OP_CYC + SAMPLES * SAMPLE_CYC + 200;

	logic     clk_i = 1'b0;
	logic     rst_ni;
	logic     bus_req_valid_i;
	logic     bus_req_ready_o;
	bus_req_t bus_req_i;
	logic     bus_rsp_valid_o;
	logic     bus_rsp_ready_i;
	bus_rsp_t bus_rsp_o;
	logic     in_valid_i;
	logic     in_ready_o;
	sample_t  in_sample_i;
	logic     out_valid_o;
	logic     out_ready_i;
	sample_t  out_sample_o;

	coeff_t ref_coef [NUM_TAPS];  // Expected memory contents
	int     ref_delay [NUM_TAPS]; // Expected delay line, index 0 newest
	int     cycle_cnt = 0;

	fir_accel_top fir_accel_top_i (.*);

	always #2 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	// One bus transfer; the response is held for stall cycles before it is taken
	task automatic bus_access(input logic [BUS_AW-1:0] addr, input logic we,
			input logic [BUS_DW-1:0] wdata, input logic [BUS_BYTES-1:0] wmask,
			input int stall, output bus_rsp_t rsp);
		bus_req_i.addr  = addr;
		bus_req_i.we    = we;
		bus_req_i.wdata = wdata;
		bus_req_i.wmask = wmask;
		bus_req_valid_i = 1'b1;
		while (!bus_req_ready_o) @(negedge clk_i);
		@(negedge clk_i);  // Request taken on the edge just passed
		bus_req_valid_i = 1'b0;
		check("bus response one cycle after request", 32'(bus_rsp_valid_o), 32'd1);
		rsp = bus_rsp_o;
		repeat (stall) begin
			@(negedge clk_i);
			check("bus response valid held", 32'(bus_rsp_valid_o), 32'd1);
			check("bus response data held", bus_rsp_o.rdata, rsp.rdata);
			check("bus response error held", 32'(bus_rsp_o.err), 32'(rsp.err));
		end
		bus_rsp_ready_i = 1'b1;
		@(negedge clk_i);
		bus_rsp_ready_i = 1'b0;
	endtask

	task automatic write_coef(input int addr, input coeff_t data, input logic [3:0] mask,
			input int stall);
		bus_rsp_t rsp;
		bus_access(BUS_AW'(addr), 1'b1, {16'($urandom), data}, mask, stall, rsp);
		check("write error flag", 32'(rsp.err), 32'(addr >= NUM_TAPS));
		check("write response data", rsp.rdata, 32'd0);
		if (addr < NUM_TAPS) begin
			for (int b = 0; b < 2; b++) begin
				if (mask[b]) ref_coef[addr][8*b +: 8] = data[8*b +: 8];  // Lanes 2, 3 ignored
			end
		end
	endtask

	task automatic read_coef(input int addr, input int stall);
		bus_rsp_t rsp;
		bus_access(BUS_AW'(addr), 1'b0, 32'($urandom), 4'hf, stall, rsp);
		if (addr < NUM_TAPS) begin
			check("read error flag", 32'(rsp.err), 32'd0);
			check("read data", rsp.rdata, {16'h0000, ref_coef[addr]});
		end else begin
			check("out-of-range error flag", 32'(rsp.err), 32'd1);
			check("out-of-range read data", rsp.rdata, 32'd0);
		end
	endtask

	// Reference filter: shift in, multiply-accumulate, round half up, clamp
	function automatic int filter_step(input int sample);
		longint acc;
		longint res;
		for (int i = NUM_TAPS - 1; i > 0; i--) ref_delay[i] = ref_delay[i-1];
		ref_delay[0] = sample;
		acc = 0;
		for (int i = 0; i < NUM_TAPS; i++) acc += longint'(ref_coef[i]) * ref_delay[i];
		res = (acc + (longint'(1) << (FRAC_BITS - 1))) >>> FRAC_BITS;
		if (res > 32767) begin
			res = 32767;
		end else if (res < -32768) begin
			res = -32768;
		end
		return int'(res);
	endfunction

	task automatic send_sample(input sample_t sample, input int stall, output sample_t got);
		int lat;
		int exp_val;
		in_sample_i = sample;
		in_valid_i  = 1'b1;
		while (!in_ready_o) @(negedge clk_i);
		@(negedge clk_i);
		in_valid_i = 1'b0;
		lat = 1;
		while (!out_valid_o) begin
			@(negedge clk_i);
			lat++;
		end
		check("sample to output latency", lat, NUM_TAPS + 2);
		got     = out_sample_o;
		exp_val = filter_step(sample);
		check("filter output", got, exp_val);
		repeat (stall) begin
			@(negedge clk_i);
			check("output valid held", 32'(out_valid_o), 32'd1);
			check("output sample held", out_sample_o, got);
		end
		out_ready_i = 1'b1;
		@(negedge clk_i);
		out_ready_i = 1'b0;
	endtask

	task automatic write_readback();
		for (int i = 0; i < NUM_TAPS; i++) write_coef(i, coeff_t'($urandom), 4'hf, 0);
		for (int i = 0; i < NUM_TAPS; i++) read_coef(i, 0);
	endtask

	task automatic masked_writes();
		write_coef(3, 16'h1111, 4'hf, 0);
		write_coef(3, 16'ha5c3, 4'b0001, 0); // Low byte only
		read_coef(3, 0);
		write_coef(3, 16'h5a3c, 4'b0010, 0); // High byte only
		read_coef(3, 0);
	endtask

	task automatic out_of_range_access();
		write_coef(NUM_TAPS, 16'h7777, 4'hf, 0);
		write_coef(255, 16'h8888, 4'hf, 0);
		read_coef(NUM_TAPS, 0);
		read_coef(255, 0);
		for (int i = 0; i < NUM_TAPS; i++) read_coef(i, 0);
	endtask

	task automatic impulse_response();
		sample_t got;
		for (int i = 0; i < NUM_TAPS; i++) begin
			send_sample((i == 0) ? sample_t'(16384) : sample_t'(0), 0, got);
			check("impulse response tap", got, ref_coef[i]);
		end
	endtask

	task automatic stream_backpressure();
		sample_t got;
		for (int i = 0; i < NUM_TAPS; i++) begin
			write_coef(i, coeff_t'($urandom_range(0, 16383) - 8192), 4'hf,
				$urandom_range(0, MAX_STALL));
		end
		for (int n = 0; n < RAND_SAMPLES; n++) begin
			send_sample(sample_t'($urandom), $urandom_range(0, MAX_STALL), got);
		end
	endtask

	task automatic saturation_clamp();
		sample_t got;
		for (int i = 0; i < NUM_TAPS; i++) write_coef(i, 16'h7fff, 4'hf, 0);
		for (int n = 0; n < NUM_TAPS; n++) send_sample(16'h7fff, 0, got);
		check("positive clamp", got, 32'h0000_7fff); // Delay line now all full-scale positive
		for (int n = 0; n < NUM_TAPS; n++) send_sample(16'h8000, 0, got);
		check("negative clamp", got, 32'hffff_8000); // Delay line now all full-scale negative
	endtask

	initial begin
		void'($urandom(32'hc853));
		rst_ni          = 1'b0;
		bus_req_valid_i = 1'b0;
		bus_req_i       = '0;
		bus_rsp_ready_i = 1'b0;
		in_valid_i      = 1'b0;
		in_sample_i     = '0;
		out_ready_i     = 1'b0;
		for (int i = 0; i < NUM_TAPS; i++) begin
			ref_coef[i]  = '0;
			ref_delay[i] = 0;
		end
		repeat (3) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);
		check("response idle after reset", 32'(bus_rsp_valid_o), 32'd0);
		check("request ready after reset", 32'(bus_req_ready_o), 32'd1);
		check("output idle after reset", 32'(out_valid_o), 32'd0);
		check("input ready after reset", 32'(in_ready_o), 32'd1);
		write_readback();
		masked_writes();
		out_of_range_access();
		impulse_response();
		stream_backpressure();
		saturation_clamp();
		$display("** PASS **");
		$finish;
	end

endmodule

// File: fir_accel.f
design/fir_bus_pkg.sv
design/fir_dsp_pkg.sv
design/coeff_bus_adapter.sv
design/coeff_dpram.sv
design/fir_mac_engine.sv
design/fir_accel_top.sv
verification/fir_accel_tb.sv
